/* hdl/ooo_pkg.sv */
/*
 * ooo core shared definitions
 * data and register index widths, word types and the ALU function code
 */
package ooo_pkg;

    localparam int XLEN      = 32;   // data width
    localparam int AREG_W    = 5;    // arch register index
    localparam int NUM_AREGS = 32;   // x0..x31

    typedef logic [XLEN-1:0]   data_t;
    typedef logic [AREG_W-1:0] areg_t;

    // alu function, 3 bits
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7    // signed compare
    } alu_func_e;

endpackage

/* hdl/ooo_ifs.sv */
/*
 * ooo core interfaces
 * cdb_if is the result broadcast bus driven by the ALU,
 * issue_if carries one ready instruction from the station to the ALU
 */
interface cdb_if import ooo_pkg::*; #(
    parameter int PRF_SIZE = 48,
    parameter int ROB_SIZE = 8
) ();
    localparam int PREG_W = $clog2(PRF_SIZE);
    localparam int ROB_W  = $clog2(ROB_SIZE);

    logic              valid;       // one broadcast per cycle
    logic              dest_valid;  // low for x0 writers
    logic [PREG_W-1:0] dest_preg;
    logic [ROB_W-1:0]  rob_idx;
    data_t             value;

    modport alu    (output valid, dest_valid, dest_preg, rob_idx, value);
    modport listen (input  valid, dest_valid, dest_preg, rob_idx, value);
endinterface

interface issue_if import ooo_pkg::*; #(
    parameter int PRF_SIZE = 48,
    parameter int ROB_SIZE = 8
) ();
    localparam int PREG_W = $clog2(PRF_SIZE);
    localparam int ROB_W  = $clog2(ROB_SIZE);

    logic              valid;       // ALU always takes it
    alu_func_e         func;
    data_t             opa;
    data_t             opb;         // register or immediate
    logic              dest_valid;
    logic [PREG_W-1:0] dest_preg;
    logic [ROB_W-1:0]  rob_idx;

    modport rs (output valid, func, opa, opb, dest_valid, dest_preg, rob_idx);
    modport fu (input  valid, func, opa, opb, dest_valid, dest_preg, rob_idx);
endinterface

/* hdl/rename_table.sv */
/*
 * rename table
 * arch to phys register map, sources looked up combinationally,
 * the destination remapped at the accept edge
 */
module rename_table import ooo_pkg::*; #(
    parameter  int PRF_SIZE = 48,
    localparam int PREG_W   = $clog2(PRF_SIZE)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  areg_t             src1,
    input  areg_t             src2,
    input  areg_t             dest,
    input  logic              rename,      // accept with dest != x0
    input  logic [PREG_W-1:0] new_preg,    // free list head
    output logic [PREG_W-1:0] src1_preg,
    output logic [PREG_W-1:0] src2_preg,
    output logic [PREG_W-1:0] old_preg     // goes back to free list at commit
);

    logic [PREG_W-1:0] amap [NUM_AREGS];

    assign src1_preg = amap[src1];
    assign src2_preg = amap[src2];
    assign old_preg  = amap[dest];   // read before the remap lands

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                amap[i] <= PREG_W'(i);   // identity, x_i -> p_i
            end
        end else if (rename) begin
            amap[dest] <= new_preg;
        end
    end

endmodule

/* hdl/phys_regfile.sv */
/*
 * physical register file
 * values and ready bits per preg, free list FIFO with a count,
 * operand reads with same-cycle bypass from the broadcast bus
 */
module phys_regfile import ooo_pkg::*; #(
    parameter  int PRF_SIZE = 48,
    localparam int PREG_W   = $clog2(PRF_SIZE)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic [PREG_W-1:0] src1_preg,
    input  logic [PREG_W-1:0] src2_preg,
    input  logic              alloc,         // pop at the accept edge
    output logic [PREG_W-1:0] free_preg,
    output logic              free_empty,
    input  logic              release_en,    // push at the commit edge
    input  logic [PREG_W-1:0] release_preg,
    cdb_if.listen             cdb,
    output logic              src1_ready,
    output logic              src2_ready,
    output data_t             src1_value,
    output data_t             src2_value
);

    localparam int FREE_N = PRF_SIZE - NUM_AREGS;             // pregs never mapped at once
    localparam int FPTR_W = (FREE_N > 1) ? $clog2(FREE_N) : 1;
    localparam int FCNT_W = $clog2(FREE_N + 1);

    data_t               values [PRF_SIZE];
    logic [PRF_SIZE-1:0] ready;
    logic [PREG_W-1:0]   free_fifo [FREE_N];
    logic [FPTR_W-1:0]   free_head;
    logic [FPTR_W-1:0]   free_tail;
    logic [FCNT_W-1:0]   free_cnt;
    logic                bus_wr;
    logic                hit1;
    logic                hit2;

    function automatic logic [FPTR_W-1:0] fptr_inc(input logic [FPTR_W-1:0] p);
        return (p == FPTR_W'(FREE_N - 1)) ? '0 : p + 1'b1;
    endfunction

    assign bus_wr = cdb.valid && cdb.dest_valid;
    assign hit1   = bus_wr && (cdb.dest_preg == src1_preg);
    assign hit2   = bus_wr && (cdb.dest_preg == src2_preg);

    // operand read, bus wins
    assign src1_ready = ready[src1_preg] || hit1;
    assign src2_ready = ready[src2_preg] || hit2;
    assign src1_value = hit1 ? cdb.value : values[src1_preg];
    assign src2_value = hit2 ? cdb.value : values[src2_preg];

    assign free_preg  = free_fifo[free_head];
    assign free_empty = (free_cnt == '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int p = 0; p < PRF_SIZE; p++) begin
                values[p] <= '0;
                ready[p]  <= (p < NUM_AREGS);   // mapped pregs start ready
            end
            for (int f = 0; f < FREE_N; f++) begin
                free_fifo[f] <= PREG_W'(NUM_AREGS + f);
            end
            free_head <= '0;
            free_tail <= '0;
            free_cnt  <= FCNT_W'(FREE_N);   // full
        end else begin
            if (bus_wr) begin
                values[cdb.dest_preg] <= cdb.value;
                ready[cdb.dest_preg]  <= 1'b1;
            end
            if (alloc) begin
                ready[free_preg] <= 1'b0;   // waits for its producer
                free_head        <= fptr_inc(free_head);
            end
            if (release_en) begin
                free_fifo[free_tail] <= release_preg;
                free_tail            <= fptr_inc(free_tail);
            end
            case ({alloc, release_en})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

endmodule

/* hdl/reorder_buffer.sv */
/*
 * reorder buffer
 * circular buffer of in-flight instructions, marked done from the bus,
 * head commits in order and hands its old preg back to the free list
 */
module reorder_buffer import ooo_pkg::*; #(
    parameter  int PRF_SIZE = 48,
    parameter  int ROB_SIZE = 8,
    localparam int PREG_W   = $clog2(PRF_SIZE),
    localparam int ROB_W    = $clog2(ROB_SIZE)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              accept,
    input  areg_t             dest,
    input  logic              dest_valid,
    input  logic [PREG_W-1:0] old_preg,
    output logic [ROB_W-1:0]  tail,
    output logic              full,
    cdb_if.listen             cdb,
    output logic              commit_valid,
    output areg_t             commit_areg,
    output data_t             commit_value,
    output logic              release_en,
    output logic [PREG_W-1:0] release_preg
);

    localparam int CNT_W = $clog2(ROB_SIZE + 1);

    logic [ROB_W-1:0]    head;
    logic [CNT_W-1:0]    count;
    logic [ROB_SIZE-1:0] done;
    logic [ROB_SIZE-1:0] has_dest;
    areg_t               ent_areg  [ROB_SIZE];
    logic [PREG_W-1:0]   ent_old   [ROB_SIZE];
    data_t               ent_value [ROB_SIZE];

    function automatic logic [ROB_W-1:0] ptr_inc(input logic [ROB_W-1:0] p);
        return (p == ROB_W'(ROB_SIZE - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full         = (count == CNT_W'(ROB_SIZE));
    assign commit_valid = (count != '0) && done[head];   // cycle after done
    assign commit_areg  = ent_areg[head];
    assign commit_value = ent_value[head];
    assign release_en   = commit_valid && has_dest[head];
    assign release_preg = ent_old[head];

    ////////////////////
    // pointers, done bits
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb.valid) begin
                done[cdb.rob_idx] <= 1'b1;
            end
            if (accept) begin
                done[tail] <= 1'b0;
                tail       <= ptr_inc(tail);
            end
            if (commit_valid) begin
                head <= ptr_inc(head);
            end
            case ({accept, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // entry payload
    always_ff @(posedge clock) begin
        if (accept) begin
            ent_areg[tail] <= dest;
            has_dest[tail] <= dest_valid;
            ent_old[tail]  <= old_preg;
        end
        if (cdb.valid) begin
            ent_value[cdb.rob_idx] <= cdb.dest_valid ? cdb.value : '0;   // x0 reads 0
        end
    end

endmodule

/* hdl/rs_alu.sv */
/*
 * ALU reservation station
 * allocates entries at dispatch, wakes them from the bus and
 * issues the oldest entry whose operands are both ready
 */
module rs_alu import ooo_pkg::*; #(
    parameter  int PRF_SIZE = 48,
    parameter  int ROB_SIZE = 8,
    parameter  int RS_SIZE  = 4,
    localparam int PREG_W   = $clog2(PRF_SIZE),
    localparam int ROB_W    = $clog2(ROB_SIZE)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              accept,
    input  alu_func_e         func,
    input  logic [PREG_W-1:0] src1_preg,
    input  logic [PREG_W-1:0] src2_preg,
    input  logic [PREG_W-1:0] dest_preg,
    input  logic              dest_valid,
    input  logic              src1_ready,
    input  logic              src2_ready,
    input  data_t             src1_value,
    input  data_t             src2_value,
    input  logic              use_imm,
    input  data_t             imm,
    input  logic [ROB_W-1:0]  rob_idx,
    output logic              full,
    cdb_if.listen             cdb,
    issue_if.rs               issue
);

    localparam int RS_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    logic [RS_SIZE-1:0] busy;
    logic [RS_SIZE-1:0] older_than [RS_SIZE];   // bit j set: j came before i
    logic [RS_SIZE-1:0] rdy1;
    logic [RS_SIZE-1:0] rdy2;
    logic [RS_SIZE-1:0] ent_dest_valid;
    logic [PREG_W-1:0]  tag1     [RS_SIZE];
    logic [PREG_W-1:0]  tag2     [RS_SIZE];
    logic [PREG_W-1:0]  ent_dest [RS_SIZE];
    logic [ROB_W-1:0]   ent_rob  [RS_SIZE];
    alu_func_e          ent_func [RS_SIZE];
    data_t              val1     [RS_SIZE];
    data_t              val2     [RS_SIZE];
    logic [RS_SIZE-1:0] can_go;
    logic [RS_SIZE-1:0] pick;
    logic [RS_W-1:0]    pick_idx;
    logic [RS_W-1:0]    free_idx;
    logic               bus_wr;

    assign bus_wr = cdb.valid && cdb.dest_valid;
    assign full   = &busy;
    assign can_go = busy & rdy1 & rdy2;

    // lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = RS_W'(i);
            end
        end
    end

    // oldest ready entry, nothing older may also be ready
    always_comb begin
        pick     = '0;
        pick_idx = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (can_go[i] && !(|(can_go & older_than[i]))) begin
                pick[i]  = 1'b1;
                pick_idx = RS_W'(i);
            end
        end
    end

    assign issue.valid      = |pick;
    assign issue.func       = ent_func[pick_idx];
    assign issue.opa        = val1[pick_idx];
    assign issue.opb        = val2[pick_idx];
    assign issue.dest_valid = ent_dest_valid[pick_idx];
    assign issue.dest_preg  = ent_dest[pick_idx];
    assign issue.rob_idx    = ent_rob[pick_idx];

    ////////////////////
    // occupancy and age order
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy <= '0;
            for (int e = 0; e < RS_SIZE; e++) begin
                older_than[e] <= '0;
            end
        end else begin
            for (int e = 0; e < RS_SIZE; e++) begin
                older_than[e] <= older_than[e] & ~pick;   // issued entry drops out
            end
            busy <= busy & ~pick;
            if (accept) begin
                busy[free_idx]       <= 1'b1;
                older_than[free_idx] <= busy & ~pick;   // youngest so far
            end
        end
    end

    ////////////////////
    // wakeup and entry write
    always_ff @(posedge clock) begin
        for (int e = 0; e < RS_SIZE; e++) begin
            if (bus_wr && !rdy1[e] && (tag1[e] == cdb.dest_preg)) begin
                rdy1[e] <= 1'b1;
                val1[e] <= cdb.value;
            end
            if (bus_wr && !rdy2[e] && (tag2[e] == cdb.dest_preg)) begin
                rdy2[e] <= 1'b1;
                val2[e] <= cdb.value;
            end
        end
        if (accept) begin
            ent_func[free_idx]       <= func;
            tag1[free_idx]           <= src1_preg;
            rdy1[free_idx]           <= src1_ready;
            val1[free_idx]           <= src1_value;
            tag2[free_idx]           <= src2_preg;
            rdy2[free_idx]           <= use_imm || src2_ready;   // imm never waits
            val2[free_idx]           <= use_imm ? imm : src2_value;
            ent_dest_valid[free_idx] <= dest_valid;
            ent_dest[free_idx]       <= dest_preg;
            ent_rob[free_idx]        <= rob_idx;
        end
    end

endmodule

/* hdl/alu.sv */
/*
 * integer ALU
 * eight functions, result and tags registered straight onto the bus
 */
module alu import ooo_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    issue_if.fu  issue,
    cdb_if.alu   cdb
);

    data_t result;

    always_comb begin
        case (issue.func)
            ALU_ADD: result = issue.opa + issue.opb;
            ALU_SUB: result = issue.opa - issue.opb;
            ALU_AND: result = issue.opa & issue.opb;
            ALU_OR:  result = issue.opa | issue.opb;
            ALU_XOR: result = issue.opa ^ issue.opb;
            ALU_SLL: result = issue.opa << issue.opb[4:0];   // low 5 bits only
            ALU_SRL: result = issue.opa >> issue.opb[4:0];
            ALU_SLT: result = data_t'($signed(issue.opa) < $signed(issue.opb));
            default: result = '0;
        endcase
    end

    // bus valid one cycle after issue
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb.dest_valid <= issue.dest_valid;
        cdb.dest_preg  <= issue.dest_preg;
        cdb.rob_idx    <= issue.rob_idx;
        cdb.value      <= result;
    end

endmodule

/* hdl/ooo_core.sv */
/*
 * out-of-order ALU core slice
 * rename, phys regfile, ROB, one reservation station and one ALU,
 * dispatch by valid/ready, commit in program order
 */
module ooo_core import ooo_pkg::*; #(
    parameter  int PRF_SIZE = 48,   // more than 32
    parameter  int ROB_SIZE = 8,
    parameter  int RS_SIZE  = 4,
    localparam int PREG_W   = $clog2(PRF_SIZE),
    localparam int ROB_W    = $clog2(ROB_SIZE)
) (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      dispatch_valid,
    input  alu_func_e func,
    input  areg_t     src1,
    input  areg_t     src2,
    input  logic      use_imm,
    input  data_t     imm,
    input  areg_t     dest,
    output logic      dispatch_ready,
    output logic      commit_valid,
    output areg_t     commit_areg,
    output data_t     commit_value
);

    logic              accept;
    logic              rename;
    logic              dest_valid;       // x0 writes stay unrenamed
    logic              rob_full;
    logic              rs_full;
    logic              free_empty;
    logic [PREG_W-1:0] src1_preg;
    logic [PREG_W-1:0] src2_preg;
    logic [PREG_W-1:0] old_preg;
    logic [PREG_W-1:0] free_preg;
    logic [PREG_W-1:0] release_preg;
    logic              release_en;
    logic              src1_ready;
    logic              src2_ready;
    data_t             src1_value;
    data_t             src2_value;
    logic [ROB_W-1:0]  rob_tail;

    cdb_if   #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) cdb ();
    issue_if #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) issue ();

    ////////////////////
    // dispatch acceptance
    assign dest_valid     = (dest != '0);
    assign dispatch_ready = !rob_full && !rs_full && !(free_empty && dest_valid);
    assign accept         = dispatch_valid && dispatch_ready;
    assign rename         = accept && dest_valid;

    rename_table #(.PRF_SIZE(PRF_SIZE)) rat0 (
        .clock(clock), .rst_n(rst_n),
        .src1(src1), .src2(src2), .dest(dest),
        .rename(rename), .new_preg(free_preg),
        .src1_preg(src1_preg), .src2_preg(src2_preg), .old_preg(old_preg)
    );

    phys_regfile #(.PRF_SIZE(PRF_SIZE)) prf0 (
        .clock(clock), .rst_n(rst_n),
        .src1_preg(src1_preg), .src2_preg(src2_preg),
        .alloc(rename), .free_preg(free_preg), .free_empty(free_empty),
        .release_en(release_en), .release_preg(release_preg),   // from ROB commit
        .cdb(cdb.listen),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .src1_value(src1_value), .src2_value(src2_value)
    );

    reorder_buffer #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) rob0 (
        .clock(clock), .rst_n(rst_n),
        .accept(accept), .dest(dest), .dest_valid(dest_valid), .old_preg(old_preg),
        .tail(rob_tail), .full(rob_full),
        .cdb(cdb.listen),
        .commit_valid(commit_valid), .commit_areg(commit_areg),
        .commit_value(commit_value),
        .release_en(release_en), .release_preg(release_preg)
    );

    ////////////////////
    // execute side
    rs_alu #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE), .RS_SIZE(RS_SIZE)) rs_alu0 (
        .clock(clock), .rst_n(rst_n),
        .accept(accept), .func(func),
        .src1_preg(src1_preg), .src2_preg(src2_preg),
        .dest_preg(free_preg), .dest_valid(dest_valid),   // preg only used if dest_valid
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .src1_value(src1_value), .src2_value(src2_value),
        .use_imm(use_imm), .imm(imm),
        .rob_idx(rob_tail), .full(rs_full),
        .cdb(cdb.listen), .issue(issue.rs)
    );

    alu alu0 (
        .clock(clock), .rst_n(rst_n),
        .issue(issue.fu),
        .cdb(cdb.alu)   // sole bus driver
    );

endmodule

/* testbench/ooo_core_chk.sv */
/*
 * ooo core protocol checker
 * bound into the core, watches reset state, dispatch and commit
 */
module ooo_core_chk import ooo_pkg::*; #(
    parameter  int ROB_SIZE = 8,
    localparam int ROB_W    = $clog2(ROB_SIZE)
) (
    input logic             clock,
    input logic             rst_n,
    input logic             dispatch_ready,
    input logic [ROB_W-1:0] rob_tail,      // moves only on an accepted dispatch
    input logic             commit_valid,
    input areg_t            commit_areg
);

    // nothing in flight right out of reset
    reset_quiet: assert property (@(posedge clock) !rst_n |=> !commit_valid)
        else $error("commit_valid high in the cycle after reset");

    // ready low, so no ROB entry may be allocated at this edge
    no_accept_stalled: assert property (@(posedge clock) disable iff (!rst_n)
        !dispatch_ready |=> $stable(rob_tail))
        else $error("ROB allocated an entry while dispatch_ready was low");

    commit_areg_known: assert property (@(posedge clock) disable iff (!rst_n)
        commit_valid |-> !$isunknown(commit_areg))
        else $error("commit_areg has unknown bits on a commit");

endmodule

bind ooo_core ooo_core_chk #(.ROB_SIZE(ROB_SIZE)) chk0 (
    .clock(clock), .rst_n(rst_n),
    .dispatch_ready(dispatch_ready),
    .rob_tail(rob_tail),
    .commit_valid(commit_valid), .commit_areg(commit_areg)
);

/* testbench/ooo_core_tb.sv */
/*
 * ooo core testbench
 * random ALU instruction stream from an LFSR, in-order reference model,
 * commit order and values compared, watchdog against a hung core
 */
module ooo_core_tb import ooo_pkg::*; ();

    localparam int NUM_INSTR  = 300;
    localparam int CLK_PERIOD = 40;
    localparam int WATCHDOG   = NUM_INSTR * 20 * CLK_PERIOD;

    logic      clock;
    logic      rst_n;
    logic      dispatch_valid;
    alu_func_e func;
    areg_t     src1;
    areg_t     src2;
    logic      use_imm;
    data_t     imm;
    areg_t     dest;
    logic      dispatch_ready;
    logic      commit_valid;
    areg_t     commit_areg;
    data_t     commit_value;

    logic [31:0] lfsr;                   // galois state
    data_t       arch_regs [NUM_AREGS];  // in-order model
    areg_t       exp_areg_q [$];
    data_t       exp_data_q [$];
    int          value_errs;
    int          proto_errs;
    int          drive_cnt;
    int          accept_cnt;
    int          commit_cnt;
    int          stall_cycles;
    int          burst_left;
    int          gap_left;

    ooo_core #(.PRF_SIZE(48), .ROB_SIZE(8), .RS_SIZE(4)) UUT (
        .clock(clock), .rst_n(rst_n),
        .dispatch_valid(dispatch_valid), .func(func),
        .src1(src1), .src2(src2), .use_imm(use_imm), .imm(imm), .dest(dest),
        .dispatch_ready(dispatch_ready),
        .commit_valid(commit_valid), .commit_areg(commit_areg),
        .commit_value(commit_value)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////
    // random source
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr[0];
            lfsr    = lfsr_step(lfsr);   // one step per bit
        end
    endtask

    // alu rules, written out from the function list
    function automatic data_t expected_result(input alu_func_e f, input data_t a, input data_t b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;   // slt
        endcase
    endfunction

    ////////////////////
    // compare tasks
    task automatic check_areg(input string name, input areg_t exp, input areg_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_commit();
        if (exp_areg_q.size() == 0) begin
            proto_errs++;
            $display("commit at %0t with no accepted instruction outstanding", $time);
        end else begin
            check_areg("commit_areg", exp_areg_q.pop_front(), commit_areg);
            check_data("commit_value", exp_data_q.pop_front(), commit_value);
        end
        commit_cnt++;
    endtask

    // model runs each accepted instruction in program order
    task automatic record_accept();
        data_t a;
        data_t b;
        data_t r;
        a = arch_regs[src1];
        b = use_imm ? imm : arch_regs[src2];
        r = expected_result(func, a, b);
        if (dest != '0) begin
            arch_regs[dest] = r;   // x0 never written
        end
        exp_areg_q.push_back(dest);
        exp_data_q.push_back((dest == '0) ? '0 : r);
        accept_cnt++;
    endtask

    task automatic new_burst();
        logic [31:0] r;
        draw_bits(5, r);
        burst_left = int'(r[4:0]) + 1;   // long enough to fill the ROB
        draw_bits(2, r);
        gap_left = int'(r[1:0]);
    endtask

    task automatic drive_instr();
        logic [31:0] r;
        draw_bits(3, r);
        func <= alu_func_e'(r[2:0]);
        draw_bits(2, r);
        src1 <= areg_t'(r[1:0]);   // x0..x3, lots of dependencies
        draw_bits(2, r);
        src2 <= areg_t'(r[1:0]);
        draw_bits(2, r);
        dest <= areg_t'(r[1:0]);
        draw_bits(2, r);
        use_imm <= (r[1:0] == 2'b00);
        draw_bits(32, r);
        imm <= r;
        dispatch_valid <= 1'b1;
    endtask

    ////////////////////
    // main sequence
    initial begin
        lfsr           = 32'd81;
        rst_n          <= 1'b0;
        dispatch_valid <= 1'b0;
        func           <= ALU_ADD;
        src1           <= '0;
        src2           <= '0;
        use_imm        <= 1'b0;
        imm            <= '0;
        dest           <= '0;
        value_errs     = 0;
        proto_errs     = 0;
        drive_cnt      = 0;
        accept_cnt     = 0;
        commit_cnt     = 0;
        stall_cycles   = 0;
        for (int i = 0; i < NUM_AREGS; i++) begin
            arch_regs[i] = '0;
        end
        new_burst();
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        // idle core after reset
        repeat (3) begin
            @(posedge clock);
            if (commit_valid || !dispatch_ready) begin
                proto_errs++;
                $display("after reset at %0t commit_valid or dispatch_ready is wrong", $time);
            end
        end
        while (commit_cnt < NUM_INSTR) begin
            @(posedge clock);
            if (commit_valid) begin
                check_commit();
            end
            if (dispatch_valid && dispatch_ready) begin
                record_accept();
            end
            if (dispatch_valid && !dispatch_ready) begin
                stall_cycles++;   // held until taken
            end else if (drive_cnt == NUM_INSTR || gap_left > 0) begin
                dispatch_valid <= 1'b0;
                if (gap_left > 0) begin
                    gap_left--;
                end
            end else begin
                drive_instr();
                drive_cnt++;
                burst_left--;
                if (burst_left == 0) begin
                    new_burst();
                end
            end
        end
        // nothing more may come out
        repeat (10) begin
            @(posedge clock);
            if (commit_valid) begin
                proto_errs++;
                $display("extra commit at %0t beyond the accepted instructions", $time);
            end
        end
        if (accept_cnt != commit_cnt || exp_areg_q.size() != 0) begin
            proto_errs++;
            $display("accepted %0d instructions but committed %0d", accept_cnt, commit_cnt);
        end
        if (stall_cycles == 0) begin
            proto_errs++;
            $display("dispatch_ready never dropped, back-pressure not exercised");
        end
        $display("errors: %0d value, %0d protocol (accepted %0d, committed %0d, stalls %0d)",
                 value_errs, proto_errs, accept_cnt, commit_cnt, stall_cycles);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG);
        $display("watchdog expired at %0t, the core stopped committing", $time);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* list.f */
hdl/ooo_pkg.sv
hdl/ooo_ifs.sv
hdl/rename_table.sv
hdl/phys_regfile.sv
hdl/reorder_buffer.sv
hdl/rs_alu.sv
hdl/alu.sv
hdl/ooo_core.sv
testbench/ooo_core_chk.sv
testbench/ooo_core_tb.sv

/* run.sh */
#!/bin/sh
# build the ooo core testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module ooo_core_tb -o ooo_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ooo_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
